// ==== list.f ====
dma_fmt_pkg.sv
cpu_q_pkg.sv
dma_align_counter.sv
dma_que_fsm.sv
dma_tx_demux.sv
dma_rx_mux.sv
dma_que_intfc.sv
tb_dma_que_intfc.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_dma_que_intfc
FLIST     = list.f
BUILD     = obj_dir
BIN       = $(BUILD)/V$(TOP)
SRCS      = $(shell cat $(FLIST))
PASS_MSG  = === PASS ===

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// ==== tb_dma_que_intfc.sv ====
`timescale 1ns/1ps

module tb_dma_que_intfc;

   import dma_fmt_pkg::*;
   import cpu_q_pkg::*;

   localparam int wait_limit = 3000;

   logic clk;
   logic reset;
   logic enable_dma;
   logic txfifo_empty;
   dma_word_t txfifo_rd_word;
   logic txfifo_rd_inc;
   logic rxfifo_nearly_full;
   logic rxfifo_wr;
   logic [rx_word_width-1:0] rxfifo_wr_data;
   logic [num_cpu_queues-1:0] cpu_q_wr;
   logic [num_cpu_queues-1:0][dma_data_width-1:0] cpu_q_wr_data;
   logic [num_cpu_queues-1:0][q_ctrl_width-1:0] cpu_q_wr_ctrl;
   logic [num_cpu_queues-1:0] cpu_q_nearly_full;
   logic [num_cpu_queues-1:0] cpu_q_rd;
   logic [num_cpu_queues-1:0][dma_data_width-1:0] cpu_q_rd_data;
   logic [num_cpu_queues-1:0][q_ctrl_width-1:0] cpu_q_rd_ctrl;

   // fifo and queue models hold {ctrl, data} entries
   logic [35:0] tx_q[$];
   logic [35:0] cq[num_cpu_queues][$];
   logic [35:0] exp_wr[num_cpu_queues][$];
   logic [rx_word_width-1:0] exp_rx[$];

   logic [31:0] stim_seed;
   logic [31:0] bp_seed;
   logic bp_on;
   logic hold_chk;
   logic [q_id_width-1:0] cur_q;
   string test_name;

   dma_que_intfc dut_i (.*);

   always #4 clk = ~clk;

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic logic [31:0] rand_stim();
      logic [31:0] hi;
      stim_seed = lcg_next(stim_seed);
      hi = stim_seed;
      stim_seed = lcg_next(stim_seed);
      return {hi[31:16], stim_seed[31:16]};
   endfunction

   // one-hot byte enable that marks the last valid byte
   // valid_bytes of 0 stands for all four bytes
   function automatic logic [3:0] onehot_ctrl(input logic [1:0] vb);
      int nbytes;
      nbytes = (vb == 2'd0) ? 4 : int'(vb);
      return 4'(1 << (nbytes - 1));
   endfunction

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic report_mismatch(input string what, input logic [63:0] expected,
                                  input logic [63:0] actual);
      stop_with_failure($sformatf("[FAIL] %s %s: expected %h, actual %h",
                                  test_name, what, expected, actual));
   endtask

   // request plus n data words toward queue qn
   // an invalid queue expects no writes
   task automatic queue_tx_packet(input logic [3:0] qn, input int n);
      logic [31:0] data;
      logic [31:0] r;
      logic eop;
      @(negedge clk);
      tx_q.push_back({1'b1, dma_dir_tx, 2'b00, 28'd0, qn});
      for (int k = 0; k < n; k++) begin
         data = rand_stim();
         r = rand_stim();
         eop = (k == n - 1);
         tx_q.push_back({1'b0, eop, r[1:0], data});
         if (int'(qn) < num_cpu_queues)
            exp_wr[qn[1:0]].push_back({eop ? onehot_ctrl(r[1:0]) : 4'b0000, data});
      end
      if (int'(qn) < num_cpu_queues && n % 2 == 1)
         exp_wr[qn[1:0]].push_back(36'd0);
   endtask

   // fills queue qn with one packet and asks for it on the host side
   task automatic queue_rx_packet(input logic [3:0] qn, input int n);
      logic [31:0] data;
      logic [31:0] r;
      logic last;
      @(negedge clk);
      for (int k = 0; k < n; k++) begin
         data = rand_stim();
         r = rand_stim();
         last = (k == n - 1);
         cq[qn[1:0]].push_back({last ? onehot_ctrl(r[1:0]) : 4'b0000, data});
         exp_rx.push_back({last, last ? r[1:0] : 2'b00, data});
      end
      // pad word that the host never sees
      if (n % 2 == 1)
         cq[qn[1:0]].push_back({4'b0000, rand_stim()});
      tx_q.push_back({1'b1, dma_dir_rx, 2'b00, 28'd0, qn});
   endtask

   task automatic wait_drained(input string what);
      int cycles;
      logic busy;
      cycles = 0;
      busy = 1'b1;
      while (busy) begin
         @(negedge clk);
         busy = (tx_q.size() != 0) || (exp_rx.size() != 0);
         for (int i = 0; i < num_cpu_queues; i++)
            busy = busy || (exp_wr[i].size() != 0) || (cq[i].size() != 0);
         cycles++;
         if (cycles > wait_limit)
            stop_with_failure($sformatf("timeout while waiting for %s to finish", what));
      end
      repeat (2) @(negedge clk);
   endtask

   //////////////////////////////////////////////////
   // models, scoreboards and input drive
   //////////////////////////////////////////////////

   always @(posedge clk) begin
      logic [35:0] head;
      logic [35:0] got;
      logic [rx_word_width-1:0] exp_word;
      if (!reset) begin
         if (txfifo_rd_inc) begin
            if (tx_q.size() == 0) begin
               stop_with_failure("transmit fifo popped while the model is empty");
            end
            else begin
               head = tx_q.pop_front();
               if (head[35])
                  cur_q <= head[3:0];
            end
         end
         for (int i = 0; i < num_cpu_queues; i++) begin
            if (cpu_q_wr[i]) begin
               got = {cpu_q_wr_ctrl[i], cpu_q_wr_data[i]};
               if (exp_wr[i].size() == 0) begin
                  stop_with_failure($sformatf("unexpected write to cpu queue %0d", i));
               end
               else begin
                  head = exp_wr[i].pop_front();
                  assert (got == head)
                     else report_mismatch($sformatf("queue %0d write", i), 64'(head), 64'(got));
               end
            end
            if (cpu_q_rd[i]) begin
               if (cq[i].size() == 0)
                  stop_with_failure($sformatf("read from empty cpu queue %0d", i));
               else
                  head = cq[i].pop_front();
            end
         end
         if (rxfifo_wr) begin
            if (exp_rx.size() == 0) begin
               stop_with_failure("unexpected write to the receive fifo");
            end
            else begin
               exp_word = exp_rx.pop_front();
               assert (rxfifo_wr_data == exp_word)
                  else report_mismatch("rx word", 64'(exp_word), 64'(rxfifo_wr_data));
            end
         end
      end

      bp_seed = lcg_next(bp_seed);
      txfifo_empty <= (tx_q.size() == 0);
      if (tx_q.size() != 0)
         txfifo_rd_word <= tx_q[0];
      else
         txfifo_rd_word <= '0;
      for (int i = 0; i < num_cpu_queues; i++) begin
         cpu_q_rd_data[i] <= (cq[i].size() != 0) ? cq[i][0][31:0] : 32'd0;
         cpu_q_rd_ctrl[i] <= (cq[i].size() != 0) ? cq[i][0][35:32] : 4'd0;
      end
      // each flag high about a quarter of the time
      cpu_q_nearly_full <= bp_on ? (bp_seed[31:28] & bp_seed[27:24]) : '0;
      rxfifo_nearly_full <= bp_on && (bp_seed[23:22] == 2'b11);
   end

   //////////////////////////////////////////////////
   // protocol checks
   //////////////////////////////////////////////////

   a_hold: assert property (@(posedge clk) disable iff (reset)
      hold_chk |-> (!txfifo_rd_inc && cpu_q_wr == '0 && cpu_q_rd == '0 && !rxfifo_wr))
      else stop_with_failure("a strobe was active while dma was disabled");

   a_rx_bp: assert property (@(posedge clk) disable iff (reset)
      rxfifo_nearly_full |-> !rxfifo_wr)
      else stop_with_failure("receive fifo written while nearly full");

   a_tx_bp_pop: assert property (@(posedge clk) disable iff (reset)
      (txfifo_rd_inc && !txfifo_rd_word.data.is_req && int'(cur_q) < num_cpu_queues)
         |-> !cpu_q_nearly_full[cur_q[1:0]])
      else stop_with_failure("transmit word popped while the cpu queue was nearly full");

   for (genvar g = 0; g < num_cpu_queues; g++) begin : g_wr_bp
      a_wr_bp: assert property (@(posedge clk) disable iff (reset)
         cpu_q_wr[g] |-> !$past(cpu_q_nearly_full[g]))
         else stop_with_failure("cpu queue written after its nearly full flag was high");
   end

   //////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////

   initial begin
      logic [31:0] r;
      clk = 1'b0;
      reset <= 1'b1;
      enable_dma <= 1'b0;
      txfifo_empty <= 1'b1;
      txfifo_rd_word <= '0;
      rxfifo_nearly_full <= 1'b0;
      cpu_q_nearly_full <= '0;
      cpu_q_rd_data <= '0;
      cpu_q_rd_ctrl <= '0;
      stim_seed = 32'd24;
      bp_seed = 32'd24;
      bp_on = 1'b0;
      hold_chk = 1'b0;
      cur_q <= '0;
      test_name = "enable_hold";
      repeat (10) @(posedge clk);
      reset <= 1'b0;

      // a pending request must stay in the fifo until dma is enabled
      @(negedge clk);
      hold_chk = 1'b1;
      queue_tx_packet(4'd0, 3);
      repeat (20) @(negedge clk);
      assert (tx_q.size() == 4)
         else report_mismatch("words left in tx fifo", 64'd4, 64'(tx_q.size()));
      hold_chk = 1'b0;
      @(posedge clk);
      enable_dma <= 1'b1;
      wait_drained("the held request");

      test_name = "tx_packets";
      bp_on = 1'b1;
      for (int p = 0; p < 12; p++) begin
         r = rand_stim();
         queue_tx_packet(4'(p % num_cpu_queues), 1 + int'(r % 7));
      end
      wait_drained("host to queue packets");

      test_name = "rx_packets";
      for (int p = 0; p < 8; p++) begin
         r = rand_stim();
         queue_rx_packet(4'(p % num_cpu_queues), 1 + int'(r % 7));
      end
      wait_drained("queue to host packets");

      // invalid queues are drained and the packets after them still arrive
      test_name = "drop";
      r = rand_stim();
      queue_tx_packet(4'(5 + r % 11), 5);
      queue_tx_packet(4'd2, 4);
      queue_tx_packet(4'd15, 2);
      queue_tx_packet(4'd1, 1);
      queue_rx_packet(4'd3, 3);
      wait_drained("dropped packets");

      $display("=== PASS ===");
      $finish;
   end

endmodule

// ==== dma_que_intfc.sv ====
`timescale 1ns/1ps

module dma_que_intfc (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 enable_dma,

   // transmit fifo from the host
   input  logic                                 txfifo_empty,
   input  dma_fmt_pkg::dma_word_t               txfifo_rd_word,
   output logic                                 txfifo_rd_inc,

   // receive fifo to the host
   input  logic                                 rxfifo_nearly_full,
   output logic                                 rxfifo_wr,
   output logic [dma_fmt_pkg::rx_word_width-1:0] rxfifo_wr_data,

   // cpu queue write side
   output logic [cpu_q_pkg::num_cpu_queues-1:0] cpu_q_wr,
   output logic [cpu_q_pkg::num_cpu_queues-1:0][dma_fmt_pkg::dma_data_width-1:0] cpu_q_wr_data,
   output logic [cpu_q_pkg::num_cpu_queues-1:0][cpu_q_pkg::q_ctrl_width-1:0] cpu_q_wr_ctrl,
   input  logic [cpu_q_pkg::num_cpu_queues-1:0] cpu_q_nearly_full,

   // cpu queue read side
   output logic [cpu_q_pkg::num_cpu_queues-1:0] cpu_q_rd,
   input  logic [cpu_q_pkg::num_cpu_queues-1:0][dma_fmt_pkg::dma_data_width-1:0] cpu_q_rd_data,
   input  logic [cpu_q_pkg::num_cpu_queues-1:0][cpu_q_pkg::q_ctrl_width-1:0] cpu_q_rd_ctrl
);

   import cpu_q_pkg::*;

   logic tx_push;
   logic tx_last;
   logic tx_pad;
   logic rx_pop;
   logic rx_pad_rd;
   logic rx_last;
   logic [q_id_width-1:0] q_id;
   logic cnt_clear;
   logic cnt_step;
   logic cnt_wrap_next;

   //////////////////////////////////////////////////
   // control
   //////////////////////////////////////////////////

   dma_que_fsm u_fsm (
      .clk                (clk),
      .reset              (reset),
      .enable_dma         (enable_dma),
      .txfifo_empty       (txfifo_empty),
      .txfifo_rd_word     (txfifo_rd_word),
      .cpu_q_nearly_full  (cpu_q_nearly_full),
      .rxfifo_nearly_full (rxfifo_nearly_full),
      .rx_last            (rx_last),
      .cnt_wrap_next      (cnt_wrap_next),
      .txfifo_rd_inc      (txfifo_rd_inc),
      .tx_push            (tx_push),
      .tx_last            (tx_last),
      .tx_pad             (tx_pad),
      .rx_pop             (rx_pop),
      .rx_pad_rd          (rx_pad_rd),
      .q_id               (q_id),
      .cnt_clear          (cnt_clear),
      .cnt_step           (cnt_step)
   );

   dma_align_counter u_align (
      .clk           (clk),
      .reset         (reset),
      .cnt_clear     (cnt_clear),
      .cnt_step      (cnt_step),
      .cnt_wrap_next (cnt_wrap_next)
   );

   //////////////////////////////////////////////////
   // data paths
   //////////////////////////////////////////////////

   dma_tx_demux u_tx_demux (
      .clk            (clk),
      .reset          (reset),
      .tx_push        (tx_push),
      .tx_last        (tx_last),
      .tx_pad         (tx_pad),
      .q_id           (q_id),
      .txfifo_rd_word (txfifo_rd_word),
      .cpu_q_wr       (cpu_q_wr),
      .cpu_q_wr_data  (cpu_q_wr_data),
      .cpu_q_wr_ctrl  (cpu_q_wr_ctrl)
   );

   dma_rx_mux u_rx_mux (
      .rx_pop         (rx_pop),
      .rx_pad_rd      (rx_pad_rd),
      .q_id           (q_id),
      .cpu_q_rd_data  (cpu_q_rd_data),
      .cpu_q_rd_ctrl  (cpu_q_rd_ctrl),
      .cpu_q_rd       (cpu_q_rd),
      .rxfifo_wr      (rxfifo_wr),
      .rxfifo_wr_data (rxfifo_wr_data),
      .rx_last        (rx_last)
   );

endmodule

// ==== dma_rx_mux.sv ====
`timescale 1ns/1ps

module dma_rx_mux (
   input  logic                                 rx_pop,
   input  logic                                 rx_pad_rd,
   input  logic [cpu_q_pkg::q_id_width-1:0]     q_id,
   input  logic [cpu_q_pkg::num_cpu_queues-1:0][dma_fmt_pkg::dma_data_width-1:0] cpu_q_rd_data,
   input  logic [cpu_q_pkg::num_cpu_queues-1:0][cpu_q_pkg::q_ctrl_width-1:0] cpu_q_rd_ctrl,
   output logic [cpu_q_pkg::num_cpu_queues-1:0] cpu_q_rd,
   output logic                                 rxfifo_wr,
   output logic [dma_fmt_pkg::rx_word_width-1:0] rxfifo_wr_data,
   output logic                                 rx_last
);

   import cpu_q_pkg::*;
   import dma_fmt_pkg::*;

   logic [$clog2(num_cpu_queues)-1:0] q_sel;
   logic [dma_data_width-1:0] head_data;
   logic [q_ctrl_width-1:0] head_ctrl;
   logic [1:0] byte_cnt;

   // queues fall through, so the head word is already on the bus
   assign q_sel = q_id[$clog2(num_cpu_queues)-1:0];
   assign head_data = cpu_q_rd_data[q_sel];
   assign head_ctrl = cpu_q_rd_ctrl[q_sel];
   assign rx_last = |head_ctrl;

   // one-hot byte enable back to a byte count, 0 means four
   always_comb begin
      case (head_ctrl)
         4'b0001: byte_cnt = 2'd1;
         4'b0010: byte_cnt = 2'd2;
         4'b0100: byte_cnt = 2'd3;
         default: byte_cnt = 2'd0;
      endcase
   end

   always_comb begin
      cpu_q_rd = '0;
      if (rx_pop || rx_pad_rd)
         cpu_q_rd[q_sel] = 1'b1;

      rxfifo_wr = rx_pop;
      rxfifo_wr_data = '0;
      if (rx_pop) begin
         rxfifo_wr_data[dma_data_width-1:0] = head_data;
         rxfifo_wr_data[rx_bytes_lsb +: 2] = byte_cnt;
         rxfifo_wr_data[rx_eop_bit] = rx_last;
      end
   end

endmodule

// ==== dma_tx_demux.sv ====
`timescale 1ns/1ps

module dma_tx_demux (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 tx_push,
   input  logic                                 tx_last,
   input  logic                                 tx_pad,
   input  logic [cpu_q_pkg::q_id_width-1:0]     q_id,
   input  dma_fmt_pkg::dma_word_t               txfifo_rd_word,
   output logic [cpu_q_pkg::num_cpu_queues-1:0] cpu_q_wr,
   output logic [cpu_q_pkg::num_cpu_queues-1:0][dma_fmt_pkg::dma_data_width-1:0] cpu_q_wr_data,
   output logic [cpu_q_pkg::num_cpu_queues-1:0][cpu_q_pkg::q_ctrl_width-1:0] cpu_q_wr_ctrl
);

   import cpu_q_pkg::*;
   import dma_fmt_pkg::*;

   logic [$clog2(num_cpu_queues)-1:0] q_sel;
   logic [dma_data_width-1:0] wr_data;
   logic [q_ctrl_width-1:0] wr_ctrl;

   assign q_sel = q_id[$clog2(num_cpu_queues)-1:0];

   // pad words carry zero data and zero control
   always_comb begin
      wr_data = tx_push ? txfifo_rd_word.data.data : '0;
      wr_ctrl = '0;
      if (tx_push && tx_last) begin
         case (txfifo_rd_word.data.valid_bytes)
            2'd0: wr_ctrl = 4'b1000;
            2'd1: wr_ctrl = 4'b0001;
            2'd2: wr_ctrl = 4'b0010;
            default: wr_ctrl = 4'b0100;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // one registered write toward the selected queue
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         cpu_q_wr <= '0;
         cpu_q_wr_data <= '0;
         cpu_q_wr_ctrl <= '0;
      end
      else begin
         for (int i = 0; i < num_cpu_queues; i++) begin
            if ((tx_push || tx_pad) && q_sel == i) begin
               cpu_q_wr[i] <= 1'b1;
               cpu_q_wr_data[i] <= wr_data;
               cpu_q_wr_ctrl[i] <= wr_ctrl;
            end
            else begin
               cpu_q_wr[i] <= 1'b0;
               cpu_q_wr_data[i] <= '0;
               cpu_q_wr_ctrl[i] <= '0;
            end
         end
      end
   end

   a_one_write: assert property (@(posedge clk) disable iff (reset)
      $onehot0(cpu_q_wr))
      else $error("more than one cpu queue written at once");

endmodule

// ==== dma_que_fsm.sv ====
`timescale 1ns/1ps

module dma_que_fsm (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              enable_dma,
   input  logic                              txfifo_empty,
   input  dma_fmt_pkg::dma_word_t            txfifo_rd_word,
   input  logic [cpu_q_pkg::num_cpu_queues-1:0] cpu_q_nearly_full,
   input  logic                              rxfifo_nearly_full,
   input  logic                              rx_last,
   input  logic                              cnt_wrap_next,
   output logic                              txfifo_rd_inc,
   output logic                              tx_push,
   output logic                              tx_last,
   output logic                              tx_pad,
   output logic                              rx_pop,
   output logic                              rx_pad_rd,
   output logic [cpu_q_pkg::q_id_width-1:0]  q_id,
   output logic                              cnt_clear,
   output logic                              cnt_step
);

   import cpu_q_pkg::*;
   import dma_fmt_pkg::*;

   que_state_t state;
   que_state_t state_next;
   logic [q_id_width-1:0] q_id_next;
   logic [q_id_width-1:0] req_q_id;
   logic req_q_valid;
   logic [$clog2(num_cpu_queues)-1:0] q_sel;
   logic q_nearly_full;

   assign req_q_id = txfifo_rd_word.req.q_field[q_id_width-1:0];
   assign req_q_valid = (req_q_id < num_cpu_queues);

   // only meaningful once a valid queue is latched
   assign q_sel = q_id[$clog2(num_cpu_queues)-1:0];
   assign q_nearly_full = cpu_q_nearly_full[q_sel];

   //////////////////////////////////////////////////
   // next state and strobes
   //////////////////////////////////////////////////

   always_comb begin
      state_next = state;
      q_id_next = q_id;
      txfifo_rd_inc = 1'b0;
      tx_push = 1'b0;
      tx_last = 1'b0;
      tx_pad = 1'b0;
      rx_pop = 1'b0;
      rx_pad_rd = 1'b0;
      cnt_clear = 1'b0;
      cnt_step = 1'b0;

      case (state)
         que_idle: begin
            if (enable_dma && !txfifo_empty) begin
               txfifo_rd_inc = 1'b1;
               cnt_clear = 1'b1;
               if (txfifo_rd_word.req.is_req) begin
                  q_id_next = req_q_id;
                  // a read from a queue that does not exist is ignored
                  if (txfifo_rd_word.req.dir == dma_dir_rx) begin
                     if (req_q_valid)
                        state_next = que_rx;
                  end
                  else if (req_q_valid) begin
                     state_next = que_tx;
                  end
                  else begin
                     state_next = que_tx_drop;
                  end
               end
            end
         end

         que_tx: begin
            if (!txfifo_empty && !q_nearly_full) begin
               txfifo_rd_inc = 1'b1;
               tx_push = 1'b1;
               tx_last = txfifo_rd_word.data.eop;
               cnt_step = 1'b1;
               if (tx_last)
                  state_next = cnt_wrap_next ? que_idle : que_tx_pad;
            end
         end

         que_tx_pad: begin
            if (!q_nearly_full) begin
               tx_pad = 1'b1;
               cnt_step = 1'b1;
               if (cnt_wrap_next)
                  state_next = que_idle;
            end
         end

         // unknown queue, throw the packet away
         que_tx_drop: begin
            if (!txfifo_empty) begin
               txfifo_rd_inc = 1'b1;
               if (txfifo_rd_word.data.eop)
                  state_next = que_idle;
            end
         end

         que_rx: begin
            if (!rxfifo_nearly_full) begin
               rx_pop = 1'b1;
               cnt_step = 1'b1;
               if (rx_last)
                  state_next = cnt_wrap_next ? que_idle : que_rx_pad;
            end
         end

         // pad words never reach the host
         que_rx_pad: begin
            rx_pad_rd = 1'b1;
            cnt_step = 1'b1;
            if (cnt_wrap_next)
               state_next = que_idle;
         end

         default: state_next = que_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= que_idle;
         q_id <= '0;
      end
      else begin
         state <= state_next;
         q_id <= q_id_next;
      end
   end

   a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
      txfifo_rd_inc |-> !txfifo_empty)
      else $error("transmit fifo popped while empty");

   a_req_in_idle: assert property (@(posedge clk) disable iff (reset)
      (state == que_idle && txfifo_rd_inc) |-> txfifo_rd_word.req.is_req)
      else $error("data word found where a request was expected");

   a_rx_backpressure: assert property (@(posedge clk) disable iff (reset)
      rxfifo_nearly_full |-> !rx_pop)
      else $error("queue read while receive fifo nearly full");

endmodule

// ==== dma_align_counter.sv ====
`timescale 1ns/1ps

module dma_align_counter (
   input  logic clk,
   input  logic reset,
   input  logic cnt_clear,
   input  logic cnt_step,
   output logic cnt_wrap_next
);

   import cpu_q_pkg::*;

   // position of the current dma word inside its datapath word
   logic [align_cnt_width-1:0] cnt;

   // next step brings the count back to zero
   assign cnt_wrap_next = (cnt == align_cnt_width'(align_ratio - 1));

   always_ff @(posedge clk) begin
      if (reset) begin
         cnt <= '0;
      end
      else if (cnt_clear) begin
         cnt <= '0;
      end
      else if (cnt_step) begin
         if (cnt_wrap_next) begin
            cnt <= '0;
         end
         else begin
            cnt <= cnt + 1'b1;
         end
      end
   end

   a_cnt_range: assert property (@(posedge clk) disable iff (reset)
      cnt < align_ratio)
      else $error("alignment count left its range");

endmodule

// ==== cpu_q_pkg.sv ====
package cpu_q_pkg;

   //////////////////////////////////////////////////
   // cpu packet queues
   //////////////////////////////////////////////////

   localparam int num_cpu_queues = 4;

   // one-hot byte enable on the last word, zero elsewhere
   localparam int q_ctrl_width = 4;

   // queue ids of num_cpu_queues and up are invalid
   localparam int q_id_width = 4;

   // dma words per user datapath word (64 over 32)
   localparam int align_ratio = 2;
   localparam int align_cnt_width = 3;

   //////////////////////////////////////////////////
   // transfer sequencer states
   //////////////////////////////////////////////////

   typedef enum logic [2:0] {
      que_idle,
      que_tx,
      que_tx_pad,
      que_tx_drop,
      que_rx,
      que_rx_pad
   } que_state_t;

endpackage

// ==== dma_fmt_pkg.sv ====
package dma_fmt_pkg;

   //////////////////////////////////////////////////
   // host dma word sizes and direction codes
   //////////////////////////////////////////////////

   localparam int dma_data_width = 32;

   // direction bit of a request word
   localparam logic dma_dir_tx = 1'b0;
   localparam logic dma_dir_rx = 1'b1;

   // receive fifo word: eop, byte count, data
   localparam int rx_word_width = 35;
   localparam int rx_eop_bit = 34;
   localparam int rx_bytes_lsb = 32;

   //////////////////////////////////////////////////
   // transmit fifo word, read as request or as data
   //////////////////////////////////////////////////

   typedef struct packed {
      logic                      is_req;
      logic                      dir;
      logic [1:0]                zero;
      logic [dma_data_width-1:0] q_field;
   } dma_req_view_t;

   // valid_bytes of 0 means all four bytes are valid
   typedef struct packed {
      logic                      is_req;
      logic                      eop;
      logic [1:0]                valid_bytes;
      logic [dma_data_width-1:0] data;
   } dma_data_view_t;

   typedef union packed {
      dma_req_view_t  req;
      dma_data_view_t data;
   } dma_word_t;

endpackage
